//--- src/fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// ----------------------------------------------------------------------
// instruction buffer
// ----------------------------------------------------------------------

// words held in the buffer, power of two
`define FETCH_BUF_ENTRIES 4

// ----------------------------------------------------------------------
// memory
// ----------------------------------------------------------------------

// instruction and data word width
`define WORD_BITS 32

// word address width, 256 words
`define MEM_ADDR_BITS 8

`endif

//--- src/fetch_pkg.sv
`default_nettype none

`include "fetch_settings.svh"

package fetch_pkg;

	// ------------------------------------------------------------------
	// data and address
	// ------------------------------------------------------------------

	// one memory word, also one instruction
	typedef logic [`WORD_BITS-1:0] word_t;

	// word address into the unified memory
	typedef logic [`MEM_ADDR_BITS-1:0] addr_t;

	// ------------------------------------------------------------------
	// buffer bookkeeping
	// ------------------------------------------------------------------

	// index into the buffer array
	typedef logic [$clog2(`FETCH_BUF_ENTRIES)-1:0] buf_ptr_t;

	// one extra bit so a full buffer is representable
	typedef logic [$clog2(`FETCH_BUF_ENTRIES):0] buf_count_t;

	// load/store port states
	typedef enum logic [1:0] {
		ls_idle,
		ls_wait_grant,
		ls_wait_data
	} ls_state_t;

endpackage

`default_nettype wire

//--- src/instruction_buffer.sv
`timescale 1ns/10ps
`default_nettype none

`include "fetch_settings.svh"

module instruction_buffer import fetch_pkg::*; (
	input  wire   clock_i,
	input  wire   resetn_i,
	input  wire   valid_i,
	input  word_t data_i,
	input  wire   read_i,
	input  wire   clear_i,
	input  wire   request_i,
	output word_t data_o,
	output logic  avail_o
);

	// ------------------------------------------------------------------
	// local signals
	// ------------------------------------------------------------------
	word_t      buf_regs [0:`FETCH_BUF_ENTRIES-1];
	buf_ptr_t   wr_ptr_q;
	buf_ptr_t   rd_ptr_q;
	buf_count_t count_q;
	buf_count_t n_active_q;
	logic       reject_q;

	logic       empty;
	logic       accepted;
	buf_count_t pending;

	// return is kept unless a clear or a pending reject eats it
	assign accepted = valid_i & ~clear_i & ~reject_q;
	assign empty    = (count_q == '0);

	// fetches still in flight once this cycle's return is counted
	assign pending  = n_active_q - buf_count_t'(valid_i);

	// ------------------------------------------------------------------
	// output side
	// ------------------------------------------------------------------

	// empty buffer passes the returning word straight through
	assign data_o  = empty ? data_i : buf_regs[rd_ptr_q];
	assign avail_o = ~empty | accepted;

	// ------------------------------------------------------------------
	// buffer control
	// ------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			wr_ptr_q   <= '0;
			rd_ptr_q   <= '0;
			count_q    <= '0;
			n_active_q <= '0;
			reject_q   <= 1'b0;
		end else begin
			// outstanding fetches, kept across a clear
			if (request_i & ~valid_i)
				n_active_q <= n_active_q + 1'b1;
			else if (~request_i & valid_i)
				n_active_q <= n_active_q - 1'b1;

			if (clear_i) begin
				wr_ptr_q <= '0;
				rd_ptr_q <= '0;
				count_q  <= '0;
				// one older fetch still on its way is stale
				reject_q <= (pending != '0);
			end else begin
				if (valid_i & reject_q)
					reject_q <= 1'b0;
				if (accepted)
					wr_ptr_q <= wr_ptr_q + 1'b1;
				if (read_i)
					rd_ptr_q <= rd_ptr_q + 1'b1;
				// a bypassed word read at once leaves the count alone
				count_q <= count_q + buf_count_t'(accepted) - buf_count_t'(read_i);
			end
		end
	end

	// storage, the bypass case writes too and is overwritten later
	always_ff @(posedge clock_i) begin
		if (accepted)
			buf_regs[wr_ptr_q] <= data_i;
	end

	// ------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------

	// consumer must follow avail_o
	a_read_when_avail: assert property (@(posedge clock_i) disable iff (!resetn_i)
		read_i |-> avail_o)
		else $error("instruction buffer read while no word available");

	// sequencer credit keeps returns from overflowing the array
	a_no_overflow: assert property (@(posedge clock_i) disable iff (!resetn_i)
		accepted |-> (count_q != buf_count_t'(`FETCH_BUF_ENTRIES)))
		else $error("instruction buffer written while full");

endmodule

`default_nettype wire

//--- src/fetch_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_sequencer import fetch_pkg::*; (
	input  wire   clock_i,
	input  wire   resetn_i,
	input  wire   redirect_i,
	input  addr_t redirect_pc_i,
	input  wire   fetch_grant_i,
	input  wire   instr_read_i,
	output logic  fetch_req_o,
	output addr_t fetch_addr_o,
	output logic  buf_clear_o,
	output addr_t instr_pc_o
);

	// ------------------------------------------------------------------
	// local signals
	// ------------------------------------------------------------------
	localparam buf_count_t DEPTH = buf_count_t'(`FETCH_BUF_ENTRIES);

	addr_t      fetch_pc_q;
	addr_t      head_pc_q;
	// words buffered plus fetches in flight
	buf_count_t credit_q;

	// ------------------------------------------------------------------
	// request side
	// ------------------------------------------------------------------

	// hold off while the buffer could not take another word
	// and never in a redirect cycle
	assign fetch_req_o  = ~redirect_i & (credit_q < DEPTH);
	assign fetch_addr_o = fetch_pc_q;

	// flush the buffer in the redirect cycle itself
	assign buf_clear_o  = redirect_i;

	assign instr_pc_o   = head_pc_q;

	// ------------------------------------------------------------------
	// program counters and credit
	// ------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			fetch_pc_q <= '0;
			head_pc_q  <= '0;
			credit_q   <= '0;
		end else if (redirect_i) begin
			// both counters restart at the target
			fetch_pc_q <= redirect_pc_i;
			head_pc_q  <= redirect_pc_i;
			credit_q   <= '0;
		end else begin
			if (fetch_grant_i)
				fetch_pc_q <= fetch_pc_q + 1'b1;
			// head moves with every consumed word
			if (instr_read_i)
				head_pc_q <= head_pc_q + 1'b1;
			credit_q <= credit_q + buf_count_t'(fetch_grant_i)
				- buf_count_t'(instr_read_i);
		end
	end

	// ------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------

	// grants and reads from other blocks must keep credit in range
	a_credit_bound: assert property (@(posedge clock_i) disable iff (!resetn_i)
		credit_q <= DEPTH)
		else $error("fetch credit above buffer depth");

endmodule

`default_nettype wire

//--- src/load_store_port.sv
`timescale 1ns/10ps
`default_nettype none

module load_store_port import fetch_pkg::*; (
	input  wire   clock_i,
	input  wire   resetn_i,
	input  wire   ls_valid_i,
	input  wire   ls_write_i,
	input  addr_t ls_addr_i,
	input  word_t ls_wdata_i,
	input  wire   ls_grant_i,
	input  wire   load_return_valid_i,
	input  word_t load_return_data_i,
	output logic  ls_busy_o,
	output logic  ls_req_o,
	output logic  ls_req_write_o,
	output addr_t ls_req_addr_o,
	output word_t ls_req_wdata_o,
	output logic  ld_valid_o,
	output word_t ld_data_o
);

	// ------------------------------------------------------------------
	// local signals
	// ------------------------------------------------------------------
	ls_state_t state_q;
	logic      write_q;
	addr_t     addr_q;
	word_t     wdata_q;
	logic      ld_valid_q;
	word_t     ld_data_q;

	assign ls_busy_o      = (state_q != ls_idle);
	assign ls_req_o       = (state_q == ls_wait_grant);
	assign ls_req_write_o = write_q;
	assign ls_req_addr_o  = addr_q;
	assign ls_req_wdata_o = wdata_q;
	assign ld_valid_o     = ld_valid_q;
	assign ld_data_o      = ld_data_q;

	// ------------------------------------------------------------------
	// FSM
	// ------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q    <= ls_idle;
			ld_valid_q <= 1'b0;
		end else begin
			ld_valid_q <= 1'b0;
			case (state_q)
				ls_idle:
					if (ls_valid_i)
						state_q <= ls_wait_grant;
				// store is done at the grant
				ls_wait_grant:
					if (ls_grant_i)
						state_q <= write_q ? ls_idle : ls_wait_data;
				ls_wait_data:
					if (load_return_valid_i) begin
						state_q    <= ls_idle;
						ld_valid_q <= 1'b1;
					end
				default:
					state_q <= ls_idle;
			endcase
		end
	end

	// command and load payload
	always_ff @(posedge clock_i) begin
		if ((state_q == ls_idle) & ls_valid_i) begin
			write_q <= ls_write_i;
			addr_q  <= ls_addr_i;
			wdata_q <= ls_wdata_i;
		end
		if ((state_q == ls_wait_data) & load_return_valid_i)
			ld_data_q <= load_return_data_i;
	end

	// one command at a time from outside
	a_no_cmd_when_busy: assert property (@(posedge clock_i) disable iff (!resetn_i)
		!(ls_valid_i && ls_busy_o))
		else $error("load/store command while port busy");

endmodule

`default_nettype wire

//--- src/memory_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module memory_arbiter import fetch_pkg::*; (
	input  wire   clock_i,
	input  wire   resetn_i,
	input  wire   ls_req_i,
	input  wire   ls_write_i,
	input  addr_t ls_addr_i,
	input  word_t ls_wdata_i,
	input  wire   fetch_req_i,
	input  addr_t fetch_addr_i,
	input  word_t mem_rdata_i,
	output logic  ls_grant_o,
	output logic  fetch_grant_o,
	output logic  mem_en_o,
	output logic  mem_write_o,
	output addr_t mem_addr_o,
	output word_t mem_wdata_o,
	output logic  fetch_return_valid_o,
	output word_t fetch_return_data_o,
	output logic  load_return_valid_o,
	output word_t load_return_data_o
);

	// ------------------------------------------------------------------
	// grant with load/store first
	// ------------------------------------------------------------------
	assign ls_grant_o    = ls_req_i;
	assign fetch_grant_o = fetch_req_i & ~ls_req_i;

	// winner goes to memory in the grant cycle
	assign mem_en_o    = ls_req_i | fetch_req_i;
	assign mem_write_o = ls_req_i & ls_write_i;
	assign mem_addr_o  = ls_req_i ? ls_addr_i : fetch_addr_i;
	assign mem_wdata_o = ls_wdata_i;

	// ------------------------------------------------------------------
	// owner pipeline that matches the two-cycle memory read
	// ------------------------------------------------------------------
	logic rd_s1_q, rd_s2_q;
	// high means the read belongs to fetch
	logic own_s1_q, own_s2_q;

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			rd_s1_q  <= 1'b0;
			rd_s2_q  <= 1'b0;
			own_s1_q <= 1'b0;
			own_s2_q <= 1'b0;
		end else begin
			rd_s1_q  <= mem_en_o & ~mem_write_o;
			own_s1_q <= fetch_grant_o;
			rd_s2_q  <= rd_s1_q;
			own_s2_q <= own_s1_q;
		end
	end

	// steer the returning word
	assign fetch_return_valid_o = rd_s2_q & own_s2_q;
	assign load_return_valid_o  = rd_s2_q & ~own_s2_q;
	assign fetch_return_data_o  = mem_rdata_i;
	assign load_return_data_o   = mem_rdata_i;

	// ------------------------------------------------------------------
	// checks
	// ------------------------------------------------------------------
	a_one_grant: assert property (@(posedge clock_i) disable iff (!resetn_i)
		!(ls_grant_o && fetch_grant_o))
		else $error("both memory grants high");

endmodule

`default_nettype wire

//--- src/unified_memory.sv
`timescale 1ns/10ps
`default_nettype none

`include "fetch_settings.svh"

module unified_memory import fetch_pkg::*; (
	input  wire   clock_i,
	input  wire   mem_en_i,
	input  wire   mem_write_i,
	input  addr_t mem_addr_i,
	input  word_t mem_wdata_i,
	output word_t mem_rdata_o
);

	// ------------------------------------------------------------------
	// storage
	// ------------------------------------------------------------------
	localparam int N_WORDS = 2 ** `MEM_ADDR_BITS;

	word_t mem_array [0:N_WORDS-1];

	// read address, first stage
	addr_t rd_addr_q;
	// read data, second stage
	word_t rdata_q;

	// write lands at the access edge
	always_ff @(posedge clock_i) begin
		if (mem_en_i & mem_write_i)
			mem_array[mem_addr_i] <= mem_wdata_i;
	end

	// two-stage read, a new read can start every cycle
	always_ff @(posedge clock_i) begin
		if (mem_en_i & ~mem_write_i)
			rd_addr_q <= mem_addr_i;
		rdata_q <= mem_array[rd_addr_q];
	end

	assign mem_rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- src/fetch_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_subsystem import fetch_pkg::*; (
	input  wire   clock_i,
	input  wire   resetn_i,
	input  wire   redirect_i,
	input  addr_t redirect_pc_i,
	input  wire   instr_read_i,
	input  wire   ls_valid_i,
	input  wire   ls_write_i,
	input  addr_t ls_addr_i,
	input  word_t ls_wdata_i,
	output word_t instr_o,
	output logic  instr_valid_o,
	output addr_t instr_pc_o,
	output logic  ls_busy_o,
	output logic  ld_valid_o,
	output word_t ld_data_o
);

	// ------------------------------------------------------------------
	// interconnect
	// ------------------------------------------------------------------

	// fetch side
	logic  fetch_req, fetch_grant, buf_clear;
	addr_t fetch_addr;
	logic  fetch_ret_valid;
	word_t fetch_ret_data;

	// load/store side
	logic  ls_req, ls_req_write, ls_grant;
	addr_t ls_req_addr;
	word_t ls_req_wdata;
	logic  load_ret_valid;
	word_t load_ret_data;

	// memory bus
	logic  mem_en, mem_write;
	addr_t mem_addr;
	word_t mem_wdata, mem_rdata;

	// ------------------------------------------------------------------
	// blocks
	// ------------------------------------------------------------------
	fetch_sequencer seq0 (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.redirect_i(redirect_i), .redirect_pc_i(redirect_pc_i),
		.fetch_grant_i(fetch_grant), .instr_read_i(instr_read_i),
		.fetch_req_o(fetch_req), .fetch_addr_o(fetch_addr),
		.buf_clear_o(buf_clear), .instr_pc_o(instr_pc_o)
	);

	// grant doubles as the outstanding-fetch count strobe
	instruction_buffer ibuf0 (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.valid_i(fetch_ret_valid), .data_i(fetch_ret_data),
		.read_i(instr_read_i), .clear_i(buf_clear), .request_i(fetch_grant),
		.data_o(instr_o), .avail_o(instr_valid_o)
	);

	load_store_port lsp0 (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.ls_valid_i(ls_valid_i), .ls_write_i(ls_write_i),
		.ls_addr_i(ls_addr_i), .ls_wdata_i(ls_wdata_i),
		.ls_grant_i(ls_grant),
		.load_return_valid_i(load_ret_valid), .load_return_data_i(load_ret_data),
		.ls_busy_o(ls_busy_o), .ls_req_o(ls_req), .ls_req_write_o(ls_req_write),
		.ls_req_addr_o(ls_req_addr), .ls_req_wdata_o(ls_req_wdata),
		.ld_valid_o(ld_valid_o), .ld_data_o(ld_data_o)
	);

	memory_arbiter arb0 (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.ls_req_i(ls_req), .ls_write_i(ls_req_write),
		.ls_addr_i(ls_req_addr), .ls_wdata_i(ls_req_wdata),
		.fetch_req_i(fetch_req), .fetch_addr_i(fetch_addr),
		.mem_rdata_i(mem_rdata),
		.ls_grant_o(ls_grant), .fetch_grant_o(fetch_grant),
		.mem_en_o(mem_en), .mem_write_o(mem_write),
		.mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata),
		.fetch_return_valid_o(fetch_ret_valid), .fetch_return_data_o(fetch_ret_data),
		.load_return_valid_o(load_ret_valid), .load_return_data_o(load_ret_data)
	);

	unified_memory mem0 (
		.clock_i(clock_i),
		.mem_en_i(mem_en), .mem_write_i(mem_write),
		.mem_addr_i(mem_addr), .mem_wdata_i(mem_wdata),
		.mem_rdata_o(mem_rdata)
	);

endmodule

`default_nettype wire

//--- tests/clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clock_gen #(
	parameter real HALF_PERIOD  = 10.0,
	parameter int  RESET_CYCLES = 5
) (
	output logic clock_o,
	output logic resetn_o
);

	// free running, 20 ns period
	initial begin
		clock_o = 1'b0;
		forever #(HALF_PERIOD) clock_o = ~clock_o;
	end

	// release just after a rising edge, like any other input
	initial begin
		resetn_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock_o);
		#1 resetn_o = 1'b1;
	end

endmodule

`default_nettype wire

//--- tests/tb_fetch_subsystem.sv
`timescale 1ns/10ps
`default_nettype none

`include "fetch_settings.svh"

module tb_fetch_subsystem import fetch_pkg::*; ();

	// ------------------------------------------------------------------
	// constants
	// ------------------------------------------------------------------
	localparam int MEM_WORDS   = 2 ** `MEM_ADDR_BITS;
	localparam int WAIT_LIMIT  = 200;
	localparam int DRIVE_DELAY = 1;
	localparam int RANDOM_SEED = 32'h69c4;

	// what wait_until polls for
	localparam int UNTIL_RESET_DONE = 0;
	localparam int UNTIL_LS_IDLE    = 1;
	localparam int UNTIL_LOAD_DATA  = 2;
	localparam int UNTIL_INSTR      = 3;

	// ------------------------------------------------------------------
	// DUT signals and bookkeeping
	// ------------------------------------------------------------------
	logic  clock;
	logic  resetn;
	logic  redirect;
	addr_t redirect_pc;
	logic  instr_read;
	logic  ls_valid;
	logic  ls_write;
	addr_t ls_addr;
	word_t ls_wdata;
	word_t instr;
	logic  instr_valid;
	addr_t instr_pc;
	logic  ls_busy;
	logic  ld_valid;
	word_t ld_data;

	// model memory, filled from the store lines
	word_t ref_mem [0:MEM_WORDS-1];
	logic  ref_known [0:MEM_WORDS-1];

	string test_name;
	int    test_count;
	int    test_fails;
	int    error_count;
	int    errors_at_start;
	logic  timed_out;

	clock_gen clk0 (.clock_o(clock), .resetn_o(resetn));

	fetch_subsystem dut0 (
		.clock_i(clock), .resetn_i(resetn),
		.redirect_i(redirect), .redirect_pc_i(redirect_pc),
		.instr_read_i(instr_read),
		.ls_valid_i(ls_valid), .ls_write_i(ls_write),
		.ls_addr_i(ls_addr), .ls_wdata_i(ls_wdata),
		.instr_o(instr), .instr_valid_o(instr_valid), .instr_pc_o(instr_pc),
		.ls_busy_o(ls_busy), .ld_valid_o(ld_valid), .ld_data_o(ld_data)
	);

	// ------------------------------------------------------------------
	// timing helpers
	// ------------------------------------------------------------------

	// inputs change here
	task automatic to_drive_point();
		@(posedge clock);
		#(DRIVE_DELAY);
	endtask

	// outputs settled mid-cycle
	task automatic to_sample_point();
		@(negedge clock);
	endtask

	task automatic report_mismatch(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("FAIL %s %s: expected %h, actual %h", test_name, what, expected, actual);
		error_count++;
	endtask

	task automatic report_problem(input string what);
		$display("ERROR %s: %s", test_name, what);
		error_count++;
	endtask

	// starts at a drive point, returns mid-cycle once the condition holds
	task automatic wait_until(input int what, input string label);
		int   n;
		logic seen;
		n = 0;
		seen = 1'b0;
		while (!seen && n < WAIT_LIMIT) begin
			to_sample_point();
			case (what)
				UNTIL_RESET_DONE: seen = (resetn === 1'b1);
				UNTIL_LS_IDLE:    seen = (ls_busy === 1'b0);
				UNTIL_LOAD_DATA:  seen = (ld_valid === 1'b1);
				default:          seen = (instr_valid === 1'b1);
			endcase
			if (!seen)
				to_drive_point();
			n++;
		end
		if (!seen) begin
			report_problem($sformatf("timed out waiting for %s", label));
			timed_out = 1'b1;
		end
	endtask

	task automatic finish_test();
		test_count++;
		if (error_count == errors_at_start) begin
			$display("ok   %s", test_name);
		end else begin
			test_fails++;
			$display("bad  %s, %0d error(s)", test_name, error_count - errors_at_start);
		end
	endtask

	// ------------------------------------------------------------------
	// command tasks
	// ------------------------------------------------------------------

	// one command into the idle port, single-cycle strobe
	task automatic issue_ls(input logic write, input addr_t addr, input word_t data);
		wait_until(UNTIL_LS_IDLE, "the load/store port to go idle");
		to_drive_point();
		ls_valid = 1'b1;
		ls_write = write;
		ls_addr  = addr;
		ls_wdata = data;
		to_drive_point();
		ls_valid = 1'b0;
	endtask

	task automatic run_redirect(input addr_t target);
		redirect    = 1'b1;
		redirect_pc = target;
		to_drive_point();
		redirect    = 1'b0;
		// stale return cycle, then the gap before the first new fetch lands
		repeat (2) begin
			to_sample_point();
			if (instr_valid !== 1'b0)
				report_mismatch("instr_valid_o after redirect", 0, instr_valid);
			if (instr_pc !== target)
				report_mismatch("instr_pc_o after redirect", target, instr_pc);
			to_drive_point();
		end
	endtask

	task automatic run_consume(input int count, input addr_t start, input int stall);
		int    i;
		int    gap;
		addr_t pc;
		for (i = 0; i < count && !timed_out; i++) begin
			pc = start + addr_t'(i);
			wait_until(UNTIL_INSTR, "an instruction word");
			if (!timed_out) begin
				to_drive_point();
				instr_read = 1'b1;
				// check while the read is held
				to_sample_point();
				if (!ref_known[pc])
					report_problem($sformatf("address %h was never stored", pc));
				else if (instr !== ref_mem[pc])
					report_mismatch($sformatf("word at %h", pc), ref_mem[pc], instr);
				if (instr_pc !== pc)
					report_mismatch("instr_pc_o", pc, instr_pc);
				to_drive_point();
				instr_read = 1'b0;
				// long gaps let the buffer fill up
				gap = $urandom_range(stall, 0);
				repeat (gap)
					to_drive_point();
			end
		end
	endtask

	// one golden line, the arguments follow the command word
	task automatic run_command(input logic [8*12-1:0] cmd, input int index, input int fd);
		int               n;
		int               count;
		int               stall;
		logic [31:0]      arg_a;
		logic [31:0]      arg_b;
		logic [8*128-1:0] rest;
		errors_at_start = error_count;
		if (cmd == "store") begin
			n = $fscanf(fd, "%h %h", arg_a, arg_b);
			test_name = $sformatf("store_%0d", index);
			if (n != 2)
				report_problem("malformed store line");
			issue_ls(1'b1, addr_t'(arg_a), arg_b);
			wait_until(UNTIL_LS_IDLE, "the store to complete");
			to_drive_point();
			ref_mem[addr_t'(arg_a)]   = arg_b;
			ref_known[addr_t'(arg_a)] = 1'b1;
		end else if (cmd == "load") begin
			n = $fscanf(fd, "%h %h", arg_a, arg_b);
			test_name = $sformatf("load_%0d", index);
			if (n != 2)
				report_problem("malformed load line");
			issue_ls(1'b0, addr_t'(arg_a), '0);
			wait_until(UNTIL_LOAD_DATA, "load data");
			if (!timed_out && ld_data !== arg_b)
				report_mismatch("ld_data_o", arg_b, ld_data);
			to_drive_point();
			// one-cycle pulse only
			to_sample_point();
			if (!timed_out && ld_valid !== 1'b0)
				report_mismatch("ld_valid_o after data", 0, ld_valid);
			to_drive_point();
		end else if (cmd == "redirect") begin
			n = $fscanf(fd, "%h", arg_a);
			test_name = $sformatf("redirect_%0d", index);
			if (n != 1)
				report_problem("malformed redirect line");
			run_redirect(addr_t'(arg_a));
		end else if (cmd == "consume") begin
			n = $fscanf(fd, "%d %h %d", count, arg_a, stall);
			test_name = $sformatf("consume_%0d", index);
			if (n != 3)
				report_problem("malformed consume line");
			run_consume(count, addr_t'(arg_a), stall);
		end else begin
			n = $fgets(rest, fd);
			test_name = $sformatf("line_%0d", index);
			report_problem("unknown command in the golden file");
		end
		finish_test();
	endtask

	// ------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------
	initial begin
		int               fd;
		int               n_read;
		int               cmd_index;
		int               a;
		logic             done;
		logic [8*12-1:0]  cmd;
		logic [8*128-1:0] comment;
		redirect    = 1'b0;
		redirect_pc = '0;
		instr_read  = 1'b0;
		ls_valid    = 1'b0;
		ls_write    = 1'b0;
		ls_addr     = '0;
		ls_wdata    = '0;
		test_count  = 0;
		test_fails  = 0;
		error_count = 0;
		timed_out   = 1'b0;
		void'($urandom(RANDOM_SEED));
		for (a = 0; a < MEM_WORDS; a++)
			ref_known[a] = 1'b0;

		// quiet outputs in the first cycle out of reset
		test_name = "reset";
		errors_at_start = error_count;
		wait_until(UNTIL_RESET_DONE, "reset release");
		if (instr_valid !== 1'b0)
			report_mismatch("instr_valid_o", 0, instr_valid);
		if (ls_busy !== 1'b0)
			report_mismatch("ls_busy_o", 0, ls_busy);
		if (ld_valid !== 1'b0)
			report_mismatch("ld_valid_o", 0, ld_valid);
		finish_test();
		to_drive_point();

		test_name = "golden_file";
		fd = $fopen("tests/fetch_golden.txt", "r");
		if (fd == 0)
			report_problem("could not open tests/fetch_golden.txt");
		done = (fd == 0);
		cmd_index = 0;
		while (!done && !timed_out) begin
			n_read = $fscanf(fd, "%s", cmd);
			if (n_read != 1) begin
				report_problem("golden file ended without an end command");
				done = 1'b1;
			end else if (cmd == "#") begin
				n_read = $fgets(comment, fd);
			end else if (cmd == "end") begin
				done = 1'b1;
			end else begin
				cmd_index++;
				run_command(cmd, cmd_index, fd);
			end
		end
		if (fd != 0)
			$fclose(fd);

		$display("tests %0d, failed %0d, errors %0d", test_count, test_fails, error_count);
		if (error_count == 0 && !timed_out)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- fetch_subsystem.f
+incdir+src
src/fetch_pkg.sv
src/instruction_buffer.sv
src/fetch_sequencer.sv
src/load_store_port.sv
src/memory_arbiter.sv
src/unified_memory.sv
src/fetch_subsystem.sv
tests/clock_gen.sv
tests/tb_fetch_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the fetch subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
	--top-module tb_fetch_subsystem -f fetch_subsystem.f \
	--Mdir "$build_dir" -o tb_fetch_subsystem

"./$build_dir/tb_fetch_subsystem" | tee "$log_file"

# the log decides, the simulator exit code is not used
if grep -qx "Testbench passed" "$log_file"; then
	echo "run_sim: pass message found"
else
	echo "run_sim: pass message missing"
	exit 1
fi

//--- tests/fetch_golden.txt
# golden stimulus, addresses and words in hex, count and stall in decimal
# store ADDR DATA | load ADDR EXPECTED | redirect ADDR | consume COUNT START STALL | end
# instruction stream at 0x10
store 10 00000013
store 11 00100093
store 12 00200113
store 13 002081b3
store 14 00418233
store 15 004202b3
store 16 00528333
store 17 006303b3
store 18 00738433
store 19 008404b3
store 1a 00948533
store 1b 00a505b3
# branch target stream at 0x40
store 40 0ff00613
store 41 00c60693
store 42 00d68733
store 43 00e707b3
store 44 00f78833
store 45 010808b3
# data region, 0x80 written twice
store 80 deadbeef
store 81 cafef00d
store 80 12345678
load 80 12345678
load 81 cafef00d
load 13 002081b3
# sequential fetch, then back-pressure
redirect 10
consume 4 10 0
consume 8 14 12
# redirect while fetches are in flight
redirect 10
consume 3 10 0
redirect 40
consume 2 40 0
# loads and stores between reads
load 81 cafef00d
consume 2 42 0
store 82 0badf00d
consume 2 44 3
load 82 0badf00d
end
